//--- bank_arbiter.sv
// Memory arbiter for one programming port and four bank read ports
// Programming always wins, banks rotate round-robin
// Tracks reads in flight and steers returning data to its bank

`default_nettype none

module bank_arbiter
    import mem_pkg::*;
(
    input  wire                            clk_sys,
    input  wire                            reset_i,
    // Programming port
    input  wire                            prog_we_i,
    input  wire [MEM_AW-1:0]               prog_addr_i,
    input  wire mem_word_t                 prog_data_i,
    input  wire byte_mask_t                prog_mask_i,
    output logic                           prog_ack_o,
    // Bank read ports
    input  wire [NBANKS-1:0]               ba_rd_i,
    input  wire [NBANKS-1:0][BANK_AW-1:0]  ba_addr_i,
    output logic [NBANKS-1:0]              ba_ack_o,
    output logic [NBANKS-1:0]              ba_rdy_o,
    output logic [DW-1:0]                  ba_dout_o,
    // Word memory
    output logic                           mem_en_o,
    output logic                           mem_we_o,
    output logic [MEM_AW-1:0]              mem_addr_o,
    output mem_word_t                      mem_din_o,
    output byte_mask_t                     mem_mask_o,
    input  wire mem_word_t                 mem_dout_i
);

    logic [BSEL_W-1:0] last_q;
    logic [BSEL_W-1:0] cand;
    logic [BSEL_W-1:0] gnt_idx;
    logic              bank_gnt;

    // Bank index of each read in flight
    logic [RD_LAT-1:0]             pipe_vld_q;
    logic [RD_LAT-1:0][BSEL_W-1:0] pipe_idx_q;

    // Search starts at the bank after the last one granted
    always_comb begin
        bank_gnt = 1'b0;
        gnt_idx  = last_q;
        cand     = last_q;
        for (int i = 1; i <= NBANKS; i++) begin
            cand = last_q + i[BSEL_W-1:0];
            if (!bank_gnt && ba_rd_i[cand]) begin
                bank_gnt = 1'b1;
                gnt_idx  = cand;
            end
        end
        // A pending download blocks every bank this cycle
        if (prog_we_i) begin
            bank_gnt = 1'b0;
        end
    end

    always_comb begin
        prog_ack_o = prog_we_i;
        ba_ack_o   = '0;
        mem_en_o   = prog_we_i || bank_gnt;
        mem_we_o   = prog_we_i;
        mem_addr_o = prog_addr_i;
        mem_mask_o = prog_mask_i;
        if (bank_gnt) begin
            ba_ack_o[gnt_idx] = 1'b1;
            mem_addr_o        = {gnt_idx, ba_addr_i[gnt_idx]};
            mem_mask_o        = 2'b11;
        end
    end

    assign mem_din_o = prog_data_i;

    always_ff @(posedge clk_sys) begin
        if (reset_i) begin
            last_q     <= BSEL_W'(NBANKS - 1);
            pipe_vld_q <= '0;
        end else begin
            pipe_vld_q <= {pipe_vld_q[RD_LAT-2:0], bank_gnt};
            if (bank_gnt) begin
                last_q <= gnt_idx;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        pipe_idx_q[0] <= gnt_idx;
        for (int i = 1; i < RD_LAT; i++) begin
            pipe_idx_q[i] <= pipe_idx_q[i-1];
        end
    end

    // Last stage lines up with the memory output register
    always_comb begin
        ba_rdy_o = '0;
        if (pipe_vld_q[RD_LAT-1]) begin
            ba_rdy_o[pipe_idx_q[RD_LAT-1]] = 1'b1;
        end
    end

    assign ba_dout_o = mem_dout_i.word;

endmodule

`default_nettype wire

//--- build.f
mem_pkg.sv
rom_dwnld.sv
bank_arbiter.sv
word_mem.sv
mem_top.sv
tb_mem_top.sv

//--- mem_patterns.hex
// Words 0-63 download, bits 26:16 byte address, bits 7:0 data byte, 16 records per bank
// Words 64-95 bank read, bits 17:16 bank, bits 7:0 word address within the bank
0001005a 000000c3 00020011 00030022 000b009e 000a0047 002000e1 0021000f
00550073 005400b8 0080002d 008100d4 00ff0066 00fe0099 01fe003c 01ff00a5
02000010 020100ef 02030034 020200cb 020a0056 020b00a9 02210078 02200087
0254009a 02550065 028100bc 02800043 02fe00de 02ff0021 03ff00f0 03fe000d
04010081 0400007e 04020092 0403006d 040b00a3 040a005c 042000b4 0421004b
045500c5 0454003a 048000d6 04810029 04ff00e7 04fe0018 05fe00f8 05ff0007
06000013 06010024 06030035 06020046 060a0057 060b0068 06210079 0620008a
0654009b 065500ac 068100bd 068000ce 06fe00df 06ff00e0 07ff00f1 07fe0002
00000000 00010001 00020005 00030010 0000002a 00010040 0002007f 000300ff
00010000 00020001 00030005 00000010 0001002a 00020040 0003007f 000000ff
00020000 00030001 00000005 00010010 0002002a 00030040 0000007f 000100ff
00030000 00000001 00010005 00020010 0003002a 00000040 0001007f 000200ff

//--- mem_pkg.sv
// Shared widths and latencies for the ROM memory subsystem
// Memory word type with whole-word and byte-lane views
// Active-low byte lane mask type

`default_nettype none

package mem_pkg;

    // Word memory geometry
    localparam int MEM_AW   = 10;
    localparam int BANK_AW  = MEM_AW - 2;
    localparam int NBANKS   = 4;
    localparam int BSEL_W   = MEM_AW - BANK_AW;
    localparam int DW       = 16;

    // Host download is byte addressed
    localparam int IOCTL_AW = MEM_AW + 1;

    // Grant to data, in clk_sys cycles
    localparam int RD_LAT   = 2;

    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } mem_lanes_t;

    // Same 16 bits, read as one value or as two bytes
    typedef union packed {
        logic [DW-1:0] word;
        mem_lanes_t    lanes;
    } mem_word_t;

    // Bit 1 high byte, bit 0 low byte, 0 writes the lane
    typedef logic [1:0] byte_mask_t;

endpackage

`default_nettype wire

//--- mem_top.sv
// Memory subsystem top level
// ROM downloader, bank arbiter and word memory

`default_nettype none

module mem_top
    import mem_pkg::*;
(
    input  wire                            clk_sys,
    input  wire                            reset_i,
    // Host download
    input  wire                            ioctl_wr_i,
    input  wire [IOCTL_AW-1:0]             ioctl_addr_i,
    input  wire [7:0]                      ioctl_dout_i,
    output logic                           ioctl_wait_o,
    // Game ROM banks
    input  wire [NBANKS-1:0]               ba_rd_i,
    input  wire [NBANKS-1:0][BANK_AW-1:0]  ba_addr_i,
    output logic [NBANKS-1:0]              ba_ack_o,
    output logic [NBANKS-1:0]              ba_rdy_o,
    output logic [DW-1:0]                  ba_dout_o
);

    logic              prog_we;
    logic              prog_ack;
    logic [MEM_AW-1:0] prog_addr;
    mem_word_t         prog_data;
    byte_mask_t        prog_mask;

    logic              mem_en;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    mem_word_t         mem_din;
    mem_word_t         mem_dout;
    byte_mask_t        mem_mask;

    rom_dwnld u_dwnld (
        .clk_sys      ( clk_sys      ),
        .reset_i      ( reset_i      ),
        .ioctl_wr_i   ( ioctl_wr_i   ),
        .ioctl_addr_i ( ioctl_addr_i ),
        .ioctl_dout_i ( ioctl_dout_i ),
        .prog_ack_i   ( prog_ack     ),
        .ioctl_wait_o ( ioctl_wait_o ),
        .prog_we_o    ( prog_we      ),
        .prog_addr_o  ( prog_addr    ),
        .prog_data_o  ( prog_data    ),
        .prog_mask_o  ( prog_mask    )
    );

    bank_arbiter u_arbiter (
        .clk_sys     ( clk_sys   ),
        .reset_i     ( reset_i   ),
        .prog_we_i   ( prog_we   ),
        .prog_addr_i ( prog_addr ),
        .prog_data_i ( prog_data ),
        .prog_mask_i ( prog_mask ),
        .prog_ack_o  ( prog_ack  ),
        .ba_rd_i     ( ba_rd_i   ),
        .ba_addr_i   ( ba_addr_i ),
        .ba_ack_o    ( ba_ack_o  ),
        .ba_rdy_o    ( ba_rdy_o  ),
        .ba_dout_o   ( ba_dout_o ),
        .mem_en_o    ( mem_en    ),
        .mem_we_o    ( mem_we    ),
        .mem_addr_o  ( mem_addr  ),
        .mem_din_o   ( mem_din   ),
        .mem_mask_o  ( mem_mask  ),
        .mem_dout_i  ( mem_dout  )
    );

    word_mem u_mem (
        .clk_sys    ( clk_sys  ),
        .mem_en_i   ( mem_en   ),
        .mem_we_i   ( mem_we   ),
        .mem_addr_i ( mem_addr ),
        .mem_din_i  ( mem_din  ),
        .mem_mask_i ( mem_mask ),
        .mem_dout_o ( mem_dout )
    );

endmodule

`default_nettype wire

//--- rom_dwnld.sv
// ROM downloader
// Turns single host bytes into masked word programming writes
// One write is held until the arbiter grants it

`default_nettype none

module rom_dwnld
    import mem_pkg::*;
(
    input  wire                clk_sys,
    input  wire                reset_i,
    input  wire                ioctl_wr_i,
    input  wire [IOCTL_AW-1:0] ioctl_addr_i,
    input  wire [7:0]          ioctl_dout_i,
    input  wire                prog_ack_i,
    output logic               ioctl_wait_o,
    output logic               prog_we_o,
    output logic [MEM_AW-1:0]  prog_addr_o,
    output mem_word_t          prog_data_o,
    output byte_mask_t         prog_mask_o
);

    logic pend_q;
    logic accept;

    // Host is not supposed to write while waiting, ignore it if it does
    assign accept = ioctl_wr_i && !pend_q;

    always_ff @(posedge clk_sys) begin
        if (reset_i) begin
            pend_q <= 1'b0;
        end else if (accept) begin
            pend_q <= 1'b1;
        end else if (prog_ack_i) begin
            pend_q <= 1'b0;
        end
    end

    // Address, data and lane select of the held byte
    always_ff @(posedge clk_sys) begin
        if (accept) begin
            prog_addr_o             <= ioctl_addr_i[IOCTL_AW-1:1];
            prog_data_o.lanes.hi    <= ioctl_dout_i;
            prog_data_o.lanes.lo    <= ioctl_dout_i;
            // Even byte goes to the low lane
            if (ioctl_addr_i[0]) begin
                prog_mask_o <= 2'b01;
            end else begin
                prog_mask_o <= 2'b10;
            end
        end
    end

    assign prog_we_o = pend_q;

    // Drops the cycle after the grant
    assign ioctl_wait_o = pend_q;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_mem_top -f build.f -o sim_mem_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_mem_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1

//--- tb_mem_top.sv
// Testbench for the ROM memory subsystem
// Host byte download and bank read drivers, byte reference model
// Ack to rdy timing monitor, read data checks, watchdog

`default_nettype none

module tb_mem_top
    import mem_pkg::*;
();

    localparam int N_DL      = 64;
    localparam int N_RD      = 32;
    localparam int WD_CYCLES = (N_DL + N_RD) * 20 + 200;

    logic                           clk_sys = 1'b0;
    logic                           reset_i;
    logic                           ioctl_wr_i;
    logic [IOCTL_AW-1:0]            ioctl_addr_i;
    logic [7:0]                     ioctl_dout_i;
    logic [NBANKS-1:0]              ba_rd_i;
    logic [NBANKS-1:0][BANK_AW-1:0] ba_addr_i;
    logic                           ioctl_wait_o;
    logic [NBANKS-1:0]              ba_ack_o;
    logic [NBANKS-1:0]              ba_rdy_o;
    logic [DW-1:0]                  ba_dout_o;

    // Download records first, then bank read records
    logic [31:0]          pat [N_DL + N_RD];
    logic [7:0]           ref_mem [2**IOCTL_AW];
    // Bank index and expected word of each read in flight
    logic [BSEL_W+DW-1:0] exp_q [$];
    logic [NBANKS-1:0]    ack_d1;
    logic [NBANKS-1:0]    ack_d2;
    int                   ack_cnt [NBANKS];
    int                   rdy_cnt [NBANKS];
    int                   n_err = 0;
    bit                   dl_busy = 1'b0;

    always #10 clk_sys = ~clk_sys;

    mem_top dut (
        .clk_sys      ( clk_sys      ),
        .reset_i      ( reset_i      ),
        .ioctl_wr_i   ( ioctl_wr_i   ),
        .ioctl_addr_i ( ioctl_addr_i ),
        .ioctl_dout_i ( ioctl_dout_i ),
        .ioctl_wait_o ( ioctl_wait_o ),
        .ba_rd_i      ( ba_rd_i      ),
        .ba_addr_i    ( ba_addr_i    ),
        .ba_ack_o     ( ba_ack_o     ),
        .ba_rdy_o     ( ba_rdy_o     ),
        .ba_dout_o    ( ba_dout_o    )
    );

    // Even byte in the low lane, odd byte in the high lane
    function automatic logic [DW-1:0] ref_word(input logic [MEM_AW-1:0] idx);
        return {ref_mem[{idx, 1'b1}], ref_mem[{idx, 1'b0}]};
    endfunction

    // Random word among those downloaded for one bank
    function automatic logic [BANK_AW-1:0] pick_addr(input int n);
        int k;
        k = n * 16 + int'($urandom % 16);
        return pat[k][24:17];
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail %s: got %h expected %h", sig, got, exp);
        n_err++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s", msg);
        n_err++;
    endtask

    task automatic check_idle();
        if (ioctl_wait_o !== 1'b0) report_mismatch("ioctl_wait_o", 32'(ioctl_wait_o), 0);
        if (ba_ack_o !== '0) report_mismatch("ba_ack_o", 32'(ba_ack_o), 0);
        if (ba_rdy_o !== '0) report_mismatch("ba_rdy_o", 32'(ba_rdy_o), 0);
    endtask

    task automatic send_byte(input logic [IOCTL_AW-1:0] a, input logic [7:0] d);
        @(negedge clk_sys);
        while (ioctl_wait_o) begin
            @(negedge clk_sys);
        end
        ioctl_wr_i   = 1'b1;
        ioctl_addr_i = a;
        ioctl_dout_i = d;
        ref_mem[a]   = d;
        @(negedge clk_sys);
        ioctl_wr_i = 1'b0;
        if (!ioctl_wait_o) report_problem($sformatf("wait did not rise after byte %h", a));
    endtask

    task automatic wait_dl_idle();
        @(negedge clk_sys);
        while (ioctl_wait_o) begin
            @(negedge clk_sys);
        end
    endtask

    // Holds the request until its ack, lat counts cycles to the ack
    task automatic read_bank(input int n, input logic [BANK_AW-1:0] a, output int lat);
        @(negedge clk_sys);
        ba_addr_i[n] = a;
        ba_rd_i[n]   = 1'b1;
        lat          = 0;
        do begin
            @(posedge clk_sys);
            lat++;
        end while (!ba_ack_o[n]);
        @(negedge clk_sys);
        ba_rd_i[n] = 1'b0;
    endtask

    task automatic keep_reading(input int n);
        int lat;
        while (dl_busy) begin
            read_bank(n, pick_addr(n), lat);
        end
    endtask

    // Lets the last reads come back, nothing may be left in flight
    task automatic drain();
        repeat (RD_LAT + 2) @(negedge clk_sys);
        if (exp_q.size() != 0) report_problem("reads still waiting for rdy");
    endtask

    // Every ack must give exactly one rdy two cycles later with model data
    always @(posedge clk_sys) begin
        logic [BSEL_W+DW-1:0] ent;
        if (reset_i) begin
            ack_d1 <= '0;
            ack_d2 <= '0;
        end else begin
            for (int n = 0; n < NBANKS; n++) begin
                if (ba_rdy_o[n] !== ack_d2[n]) begin
                    report_mismatch($sformatf("ba_rdy_o[%0d]", n), 32'(ba_rdy_o[n]),
                                    32'(ack_d2[n]));
                end
                if (ba_rdy_o[n]) begin
                    rdy_cnt[n]++;
                    if (exp_q.size() == 0) begin
                        report_problem($sformatf("bank %0d rdy with no read pending", n));
                    end else begin
                        ent = exp_q.pop_front();
                        if (ent[DW +: BSEL_W] !== n[BSEL_W-1:0]) begin
                            report_mismatch("ba_rdy_o bank", 32'(n),
                                            32'(ent[DW +: BSEL_W]));
                        end
                        if (ba_dout_o !== ent[DW-1:0]) begin
                            report_mismatch($sformatf("ba_dout_o bank %0d", n),
                                            32'(ba_dout_o), 32'(ent[DW-1:0]));
                        end
                    end
                end
                if (ba_ack_o[n]) begin
                    ack_cnt[n]++;
                    exp_q.push_back({n[BSEL_W-1:0],
                                     ref_word({n[BSEL_W-1:0], ba_addr_i[n]})});
                end
            end
            ack_d1 <= ba_ack_o;
            ack_d2 <= ack_d1;
        end
    end

    initial begin
        int lat;
        int total;
        int lats [NBANKS];
        int base [NBANKS];
        void'($urandom(32'hcc740c4b));
        $readmemh("mem_patterns.hex", pat);
        reset_i      = 1'b1;
        ioctl_wr_i   = 1'b0;
        ioctl_addr_i = '0;
        ioctl_dout_i = '0;
        ba_rd_i      = '0;
        ba_addr_i    = '0;
        for (int n = 0; n < NBANKS; n++) begin
            ack_cnt[n] = 0;
            rdy_cnt[n] = 0;
        end
        repeat (8) begin
            @(negedge clk_sys);
            check_idle();
        end
        reset_i = 1'b0;
        @(negedge clk_sys);
        check_idle();

        // Full download, then every file read
        for (int i = 0; i < N_DL; i++) begin
            send_byte(pat[i][26:16], pat[i][7:0]);
        end
        wait_dl_idle();
        for (int i = 0; i < N_RD; i++) begin
            read_bank(int'(pat[N_DL+i][17:16]), pat[N_DL+i][7:0], lat);
        end
        drain();

        // All four banks at once
        for (int n = 0; n < NBANKS; n++) begin
            base[n] = ack_cnt[n];
        end
        fork
            read_bank(0, pick_addr(0), lats[0]);
            read_bank(1, pick_addr(1), lats[1]);
            read_bank(2, pick_addr(2), lats[2]);
            read_bank(3, pick_addr(3), lats[3]);
        join
        drain();
        for (int n = 0; n < NBANKS; n++) begin
            if (lats[n] > 5) report_problem($sformatf("bank %0d ack took %0d cycles", n, lats[n]));
            if (ack_cnt[n] - base[n] != 1) report_problem($sformatf("bank %0d ack count", n));
        end

        // New bank 3 bytes while banks 0 to 2 keep reading
        dl_busy = 1'b1;
        fork
            begin
                for (int i = 48; i < N_DL; i++) begin
                    send_byte(pat[i][26:16], 8'($urandom));
                end
                wait_dl_idle();
                dl_busy = 1'b0;
            end
            keep_reading(0);
            keep_reading(1);
            keep_reading(2);
        join
        drain();
        for (int i = 0; i < N_RD; i++) begin
            if (pat[N_DL+i][17:16] == 2'd3) read_bank(3, pat[N_DL+i][7:0], lat);
        end
        drain();

        total = 0;
        for (int n = 0; n < NBANKS; n++) begin
            total += ack_cnt[n];
            if (ack_cnt[n] != rdy_cnt[n]) begin
                report_problem($sformatf("bank %0d had %0d acks and %0d rdy pulses",
                                         n, ack_cnt[n], rdy_cnt[n]));
            end
        end
        $display("Run complete: %0d errors over %0d bank reads", n_err, total);
        if (n_err == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk_sys);
        $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- word_mem.sv
// Synchronous word memory, stand-in for the SDRAM
// Byte-lane writes under an active-low mask
// Reads take two cycles through address and output registers

`default_nettype none

module word_mem
    import mem_pkg::*;
(
    input  wire               clk_sys,
    input  wire               mem_en_i,
    input  wire               mem_we_i,
    input  wire [MEM_AW-1:0]  mem_addr_i,
    input  wire mem_word_t    mem_din_i,
    input  wire byte_mask_t   mem_mask_i,
    output mem_word_t         mem_dout_o
);

    mem_word_t         mem_array [2**MEM_AW];
    logic [MEM_AW-1:0] rd_addr_q;

    // Each lane written on its own
    always_ff @(posedge clk_sys) begin
        if (mem_en_i && mem_we_i) begin
            if (!mem_mask_i[0]) begin
                mem_array[mem_addr_i].lanes.lo <= mem_din_i.lanes.lo;
            end
            if (!mem_mask_i[1]) begin
                mem_array[mem_addr_i].lanes.hi <= mem_din_i.lanes.hi;
            end
        end
    end

    // First read stage holds the address
    always_ff @(posedge clk_sys) begin
        if (mem_en_i && !mem_we_i) begin
            rd_addr_q <= mem_addr_i;
        end
    end

    // Second stage registers the word
    always_ff @(posedge clk_sys) begin
        mem_dout_o <= mem_array[rd_addr_q];
    end

endmodule

`default_nettype wire
